// ==== stream_dma_pkg.sv ====
package stream_dma_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int NUM_CH      = 2;
    localparam int BURST_LEN   = 16;
    localparam int FIFO_DEPTH  = 64;
    localparam int WORD_BYTES  = 4;
    localparam int BURST_BYTES = BURST_LEN * WORD_BYTES;  // pointer step per burst.
    localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
    localparam int BEAT_W      = $clog2(BURST_LEN);

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [23:0] pixel_t;
    typedef logic [7:0]  len_t;
    typedef logic [1:0]  resp_t;
    typedef logic [0:0]  ch_id_t;
    typedef logic [3:0]  reg_addr_t;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam resp_t      RESP_OKAY      = 2'b00;

    // ------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------
    localparam reg_addr_t REG_START0 = 4'd0;
    localparam reg_addr_t REG_END0   = 4'd1;
    localparam reg_addr_t REG_START1 = 4'd2;
    localparam reg_addr_t REG_END1   = 4'd3;
    localparam reg_addr_t REG_CTRL   = 4'd4;   // one enable bit per channel.
    localparam reg_addr_t REG_STATUS = 4'd5;   // write 1 to clear.

    localparam int STATUS_ERR_BIT = 2;         // overflow flags sit below it.

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } wr_state_t;

endpackage

// ==== dma_capture_regs.sv ====
`timescale 1ns/1ps

module dma_capture_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  stream_dma_pkg::reg_addr_t         reg_addr,
    input  stream_dma_pkg::word_t             reg_wdata,
    output stream_dma_pkg::word_t             reg_rdata,
    output stream_dma_pkg::addr_t             start_addr [stream_dma_pkg::NUM_CH],
    output stream_dma_pkg::addr_t             end_addr   [stream_dma_pkg::NUM_CH],
    output logic [stream_dma_pkg::NUM_CH-1:0] capture_en,
    input  logic [stream_dma_pkg::NUM_CH-1:0] overflow_pulse,
    input  logic                              wr_error_pulse
);
    import stream_dma_pkg::*;

    logic [NUM_CH-1:0] ovf_flag;
    logic              err_flag;
    logic              status_wr;
    word_t             status_word;

    assign status_wr = reg_wr && (reg_addr == REG_STATUS);

    always_comb begin
        status_word                 = '0;
        status_word[NUM_CH-1:0]     = ovf_flag;
        status_word[STATUS_ERR_BIT] = err_flag;
    end

    // ------------------------------------------------------------------
    // windows and control
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                start_addr[ch] <= '0;
                end_addr[ch]   <= '0;
            end
            capture_en <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_START0: start_addr[0] <= reg_wdata;
                REG_END0:   end_addr[0]   <= reg_wdata;   // last byte of the window.
                REG_START1: start_addr[1] <= reg_wdata;
                REG_END1:   end_addr[1]   <= reg_wdata;
                REG_CTRL:   capture_en    <= reg_wdata[NUM_CH-1:0];
                default: ;
            endcase
        end
    end

    // sticky flags, a new event wins over a clear in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            ovf_flag <= '0;
            err_flag <= 1'b0;
        end else begin
            ovf_flag <= (ovf_flag & ~(status_wr ? reg_wdata[NUM_CH-1:0] : '0)) | overflow_pulse;
            err_flag <= (err_flag & ~(status_wr && reg_wdata[STATUS_ERR_BIT])) | wr_error_pulse;
        end
    end

    // ------------------------------------------------------------------
    // read port
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (reg_addr)
                REG_START0: reg_rdata <= start_addr[0];
                REG_END0:   reg_rdata <= end_addr[0];
                REG_START1: reg_rdata <= start_addr[1];
                REG_END1:   reg_rdata <= end_addr[1];
                REG_CTRL:   reg_rdata <= word_t'(capture_en);
                REG_STATUS: reg_rdata <= status_word;
                default:    reg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== capture_channel.sv ====
`timescale 1ns/1ps

module capture_channel (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture_en,
    input  logic                   vsync,
    input  logic                   de,
    input  stream_dma_pkg::pixel_t rgb,
    input  logic                   pop,
    output stream_dma_pkg::word_t  fifo_data,
    output logic                   burst_avail,
    output logic                   overflow_pulse
);
    import stream_dma_pkg::*;

    logic vsync_q;
    logic armed;
    logic pix_valid;

    word_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               empty;
    logic               push;
    logic               pull;

    // ------------------------------------------------------------------
    // frame arming
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            vsync_q <= 1'b0;
            armed   <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (!capture_en) begin
                armed <= 1'b0;                 // disable drops the frame.
            end else if (vsync && !vsync_q) begin
                armed <= 1'b1;
            end
        end
    end

    assign pix_valid = armed && de;

    // ------------------------------------------------------------------
    // pixel fifo
    // ------------------------------------------------------------------
    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = pix_valid && !full;
    assign pull  = pop && !empty;

    assign overflow_pulse = pix_valid && full;   // pixel lost.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= word_t'(rgb);           // upper byte zero.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head of the queue is visible before the pop.
    assign fifo_data = mem[rd_ptr];

    assign burst_avail = (count >= (FIFO_AW+1)'(BURST_LEN));

endmodule

// ==== axi_burst_writer.sv ====
`timescale 1ns/1ps

module axi_burst_writer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  stream_dma_pkg::addr_t                 start_addr [stream_dma_pkg::NUM_CH],
    input  stream_dma_pkg::addr_t                 end_addr   [stream_dma_pkg::NUM_CH],
    input  logic [stream_dma_pkg::NUM_CH-1:0]     capture_en,
    input  logic [stream_dma_pkg::NUM_CH-1:0]     burst_avail,
    output logic [stream_dma_pkg::NUM_CH-1:0]     pop,
    input  stream_dma_pkg::word_t                 fifo_data  [stream_dma_pkg::NUM_CH],
    output logic                                  wr_error_pulse,

    output stream_dma_pkg::ch_id_t                awid,
    output stream_dma_pkg::addr_t                 awaddr,
    output stream_dma_pkg::len_t                  awlen,
    output logic [1:0]                            awburst,
    output logic                                  awvalid,
    input  logic                                  awready,
    output stream_dma_pkg::word_t                 wdata,
    output logic [stream_dma_pkg::WORD_BYTES-1:0] wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    input  logic                                  wready,
    input  stream_dma_pkg::ch_id_t                bid,
    input  stream_dma_pkg::resp_t                 bresp,
    input  logic                                  bvalid,
    output logic                                  bready
);
    import stream_dma_pkg::*;

    wr_state_t         state;
    ch_id_t            cur_ch;
    ch_id_t            last_ch;
    ch_id_t            pick;
    logic              pick_valid;
    logic [BEAT_W-1:0] beat_cnt;
    logic              last_beat;
    logic              aw_fire;
    logic              w_fire;
    logic              b_fire;
    addr_t             addr_ptr [NUM_CH];
    addr_t             advance;
    addr_t             next_ptr;
    logic [NUM_CH-1:0] capture_en_q;

    // ------------------------------------------------------------------
    // bus outputs
    // ------------------------------------------------------------------
    assign awvalid = (state == ADDR);
    assign wvalid  = (state == DATA);
    assign bready  = (state == RESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    assign awid    = cur_ch;
    assign awlen   = len_t'(BURST_LEN - 1);
    assign awburst = AXI_BURST_INCR;

    assign last_beat = (beat_cnt == BEAT_W'(BURST_LEN - 1));
    assign wdata     = fifo_data[cur_ch];       // fifo head, stable until popped.
    assign wstrb     = '1;
    assign wlast     = wvalid && last_beat;

    // unexpected id counts as a failed write too.
    assign wr_error_pulse = b_fire && ((bresp != RESP_OKAY) || (bid != cur_ch));

    always_comb begin
        pop = '0;
        if (w_fire) begin
            pop[cur_ch] = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // round-robin pick, starting after the channel served last
    // ------------------------------------------------------------------
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = last_ch;
        for (int i = 1; i <= NUM_CH; i++) begin
            idx = (int'(last_ch) + i) % NUM_CH;
            if (!pick_valid && burst_avail[idx]) begin
                pick_valid = 1'b1;
                pick       = ch_id_t'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            cur_ch   <= '0;
            last_ch  <= ch_id_t'(NUM_CH - 1);   // channel 0 goes first.
            beat_cnt <= '0;
            awaddr   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pick_valid) begin
                        cur_ch <= pick;
                        awaddr <= addr_ptr[pick];
                        state  <= ADDR;
                    end
                end
                ADDR: begin
                    if (aw_fire) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (w_fire) begin
                        if (last_beat) begin
                            beat_cnt <= '0;
                            state    <= RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                RESP: begin
                    if (b_fire) begin
                        last_ch <= cur_ch;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // per-channel write pointers
    // ------------------------------------------------------------------
    always_comb begin
        advance = addr_ptr[cur_ch] + addr_t'(BURST_BYTES);
        if (advance + addr_t'(BURST_BYTES - 1) > end_addr[cur_ch]) begin
            next_ptr = start_addr[cur_ch];      // next burst would leave the window.
        end else begin
            next_ptr = advance;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            capture_en_q <= '0;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                addr_ptr[ch] <= '0;
            end
        end else begin
            capture_en_q <= capture_en;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (capture_en[ch] && !capture_en_q[ch]) begin
                    addr_ptr[ch] <= start_addr[ch];
                end else if (b_fire && (cur_ch == ch_id_t'(ch))) begin
                    addr_ptr[ch] <= next_ptr;
                end
            end
        end
    end

endmodule

// ==== stream_dma_top.sv ====
`timescale 1ns/1ps

module stream_dma_top (
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic                                  reg_wr,
    input  logic                                  reg_rd,
    input  stream_dma_pkg::reg_addr_t             reg_addr,
    input  stream_dma_pkg::word_t                 reg_wdata,
    output stream_dma_pkg::word_t                 reg_rdata,

    input  logic [stream_dma_pkg::NUM_CH-1:0]     vsync,
    input  logic [stream_dma_pkg::NUM_CH-1:0]     de,
    input  stream_dma_pkg::pixel_t                rgb [stream_dma_pkg::NUM_CH],

    output stream_dma_pkg::ch_id_t                awid,
    output stream_dma_pkg::addr_t                 awaddr,
    output stream_dma_pkg::len_t                  awlen,
    output logic [1:0]                            awburst,
    output logic                                  awvalid,
    input  logic                                  awready,
    output stream_dma_pkg::word_t                 wdata,
    output logic [stream_dma_pkg::WORD_BYTES-1:0] wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    input  logic                                  wready,
    input  stream_dma_pkg::ch_id_t                bid,
    input  stream_dma_pkg::resp_t                 bresp,
    input  logic                                  bvalid,
    output logic                                  bready
);
    import stream_dma_pkg::*;

    addr_t             start_addr [NUM_CH];
    addr_t             end_addr   [NUM_CH];
    logic [NUM_CH-1:0] capture_en;
    logic [NUM_CH-1:0] overflow_pulse;
    logic [NUM_CH-1:0] burst_avail;
    logic [NUM_CH-1:0] pop;
    word_t             fifo_data  [NUM_CH];
    logic              wr_error_pulse;

    dma_capture_regs regs_i (
        .clk            ( clk            ),
        .rst            ( rst            ),
        .reg_wr         ( reg_wr         ),
        .reg_rd         ( reg_rd         ),
        .reg_addr       ( reg_addr       ),
        .reg_wdata      ( reg_wdata      ),
        .reg_rdata      ( reg_rdata      ),
        .start_addr     ( start_addr     ),
        .end_addr       ( end_addr       ),
        .capture_en     ( capture_en     ),
        .overflow_pulse ( overflow_pulse ),
        .wr_error_pulse ( wr_error_pulse )
    );

    // ------------------------------------------------------------------
    // capture channels
    // ------------------------------------------------------------------
    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        capture_channel channel_i (
            .clk            ( clk                ),
            .rst            ( rst                ),
            .capture_en     ( capture_en[ch]     ),
            .vsync          ( vsync[ch]          ),
            .de             ( de[ch]             ),
            .rgb            ( rgb[ch]            ),
            .pop            ( pop[ch]            ),
            .fifo_data      ( fifo_data[ch]      ),
            .burst_avail    ( burst_avail[ch]    ),
            .overflow_pulse ( overflow_pulse[ch] )
        );
    end

    axi_burst_writer writer_i (
        .clk            ( clk            ),
        .rst            ( rst            ),
        .start_addr     ( start_addr     ),
        .end_addr       ( end_addr       ),
        .capture_en     ( capture_en     ),
        .burst_avail    ( burst_avail    ),
        .pop            ( pop            ),
        .fifo_data      ( fifo_data      ),
        .wr_error_pulse ( wr_error_pulse ),
        .awid           ( awid           ),
        .awaddr         ( awaddr         ),
        .awlen          ( awlen          ),
        .awburst        ( awburst        ),
        .awvalid        ( awvalid        ),
        .awready        ( awready        ),
        .wdata          ( wdata          ),
        .wstrb          ( wstrb          ),
        .wlast          ( wlast          ),
        .wvalid         ( wvalid         ),
        .wready         ( wready         ),
        .bid            ( bid            ),
        .bresp          ( bresp          ),
        .bvalid         ( bvalid         ),
        .bready         ( bready         )
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD_NS = 2;   // 4 ns clock.
    localparam int RST_CYCLES     = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== stream_dma_props.sv ====
`timescale 1ns/1ps

module stream_dma_props (
    input logic                      clk,
    input logic                      rst,
    input stream_dma_pkg::wr_state_t state,
    input stream_dma_pkg::ch_id_t    awid,
    input stream_dma_pkg::addr_t     awaddr,
    input stream_dma_pkg::len_t      awlen,
    input logic                      awvalid,
    input logic                      awready,
    input stream_dma_pkg::word_t     wdata,
    input logic                      wlast,
    input logic                      wvalid,
    input logic                      wready
);
    import stream_dma_pkg::*;

    logic [BEAT_W:0] beats;   // W beats taken in this burst.

    always_ff @(posedge clk) begin
        if (rst) begin
            beats <= '0;
        end else if (wvalid && wready) begin
            if (beats == (BEAT_W+1)'(BURST_LEN - 1)) begin
                beats <= '0;
            end else begin
                beats <= beats + 1'b1;
            end
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=>
            awvalid && $stable(awaddr) && $stable(awid) && $stable(awlen))
        else $error("AW request dropped or changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("W beat dropped or changed before wready");

    last_beat: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> (wlast == (beats == (BEAT_W+1)'(BURST_LEN - 1))))
        else $error("wlast not on the final beat of the burst");

    aw_start: assert property (@(posedge clk) disable iff (rst)
        $rose(awvalid) |-> ($past(state) == IDLE) && (state == ADDR))
        else $error("awvalid raised outside the IDLE to ADDR step");

endmodule

// ==== stream_dma_tb.sv ====
`timescale 1ns/1ps

module stream_dma_tb;
    import stream_dma_pkg::*;

    localparam int TOTAL_PIXELS     = 360;
    localparam int CYCLES_PER_PIXEL = 8;
    localparam int MARGIN_CYCLES    = 2000;
    localparam int CLK_PERIOD_NS    = 4;
    localparam int TIMEOUT_NS = (TOTAL_PIXELS * CYCLES_PER_PIXEL + MARGIN_CYCLES) * CLK_PERIOD_NS;

    logic                  clk;
    logic                  rst;
    logic                  reg_wr;
    logic                  reg_rd;
    reg_addr_t             reg_addr;
    word_t                 reg_wdata;
    word_t                 reg_rdata;
    logic [NUM_CH-1:0]     vsync;
    logic [NUM_CH-1:0]     de;
    pixel_t                rgb [NUM_CH];
    ch_id_t                awid;
    addr_t                 awaddr;
    len_t                  awlen;
    logic [1:0]            awburst;
    logic                  awvalid;
    logic                  awready;
    word_t                 wdata;
    logic [WORD_BYTES-1:0] wstrb;
    logic                  wlast;
    logic                  wvalid;
    logic                  wready;
    ch_id_t                bid;
    resp_t                 bresp;
    logic                  bvalid;
    logic                  bready;

    // slave memory model state
    word_t       mem [addr_t];
    addr_t       burst_addr_q [$];
    ch_id_t      burst_id_q [$];
    addr_t       w_addr;
    int          w_beat;
    ch_id_t      b_id;
    logic        b_pending;
    int          bursts_done;
    logic        rand_ready;
    logic        hold_wready;
    logic        force_err;
    logic [31:0] lfsr = 32'hd1e5_c827;

    tb_clock_gen clock_gen_i (
        .clk ( clk ),
        .rst ( rst )
    );

    stream_dma_top stream_dma_top_i (.*);

    bind axi_burst_writer stream_dma_props props_i (.*);

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic logic take_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // x^32+x^22+x^2+x+1.
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic pixel_t pixel_value(input int tag, input int ch, input int idx);
        return pixel_t'((tag << 16) | (ch << 12) | idx);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: %s = 0x%08h, expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        #1;
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    task automatic set_window(input int ch, input addr_t start, input addr_t bytes);
        write_reg((ch == 0) ? REG_START0 : REG_START1, start);
        write_reg((ch == 0) ? REG_END0 : REG_END1, start + bytes - 1);
    endtask

    task automatic pulse_vsync(input logic [NUM_CH-1:0] mask);
        vsync = mask;
        @(posedge clk);
        #1;
        vsync = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic send_pixels(input logic [NUM_CH-1:0] mask, input int n, input int tag);
        for (int i = 0; i < n; i++) begin
            de = mask;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                rgb[ch] = pixel_value(tag, ch, i);
            end
            @(posedge clk);
            #1;
        end
        de = '0;
    endtask

    task automatic wait_bursts(input int target);
        while (bursts_done < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic verify_window(input addr_t base, input int tag, input int ch,
                                 input int first, input int n);
        addr_t a;
        for (int k = 0; k < n; k++) begin
            a = base + addr_t'(4 * k);
            check_value($sformatf("mem[%08h]", a), mem[a],
                        {8'h00, pixel_value(tag, ch, first + k)});
        end
    endtask

    // ------------------------------------------------------------------
    // AXI slave memory model
    // ------------------------------------------------------------------
    initial begin
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bid         = '0;
        bresp       = 2'b00;
        w_addr      = '0;
        w_beat      = 0;
        b_id        = '0;
        b_pending   = 1'b0;
        bursts_done = 0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (awvalid && awready) begin
                    check_value("awlen", 32'(awlen), 32'(BURST_LEN - 1));
                    check_value("awburst", 32'(awburst), 32'h1);   // INCR.
                    burst_addr_q.push_back(awaddr);
                    burst_id_q.push_back(awid);
                    w_addr = awaddr;
                    w_beat = 0;
                    b_id   = awid;
                end
                if (wvalid && wready) begin
                    check_value("wstrb", 32'(wstrb), 32'hf);
                    check_value("wlast", 32'(wlast), 32'(w_beat == BURST_LEN - 1));
                    mem[w_addr] = wdata;
                    w_addr      = w_addr + 4;
                    w_beat      = w_beat + 1;
                    if (wlast) begin
                        b_pending = 1'b1;
                    end
                end
                if (bvalid && bready) begin
                    b_pending   = 1'b0;
                    bursts_done = bursts_done + 1;
                end
            end
            #1;
            awready = rand_ready ? take_bit() : 1'b1;
            wready  = hold_wready ? 1'b0 : (rand_ready ? take_bit() : 1'b1);
            bvalid  = b_pending;
            bid     = b_id;
            bresp   = force_err ? 2'b10 : 2'b00;   // SLVERR when forced.
        end
    end

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic check_reset_and_regs();
        word_t rd;
        word_t val;
        check_value("awvalid", 32'(awvalid), 32'h0);
        check_value("wvalid", 32'(wvalid), 32'h0);
        check_value("bready", 32'(bready), 32'h0);
        check_value("reg_rdata", reg_rdata, 32'h0);
        read_reg(REG_STATUS, rd);
        check_value("status", rd, 32'h0);
        read_reg(REG_CTRL, rd);
        check_value("ctrl after reset", rd, 32'h0);
        for (int r = 0; r < 4; r++) begin
            val = word_t'(32'h0100_0000 * (r + 1) + 32'h40 * r);
            write_reg(reg_addr_t'(r), val);
            read_reg(reg_addr_t'(r), rd);
            check_value($sformatf("window reg %0d", r), rd, val);
        end
        write_reg(REG_CTRL, 32'h3);
        read_reg(REG_CTRL, rd);
        check_value("ctrl", rd, 32'h3);
        write_reg(REG_CTRL, 32'h0);
    endtask

    task automatic capture_single_channel();
        addr_t base;
        int    first;
        base  = 32'h1000_0000;
        first = bursts_done;
        set_window(0, base, 32'h400);
        write_reg(REG_CTRL, 32'h1);
        send_pixels(2'b01, 8, 8'h2f);        // not armed yet.
        pulse_vsync(2'b01);
        send_pixels(2'b01, 32, 8'h20);
        wait_bursts(first + 2);
        check_value("burst 0 awaddr", burst_addr_q[first], base);
        check_value("burst 1 awaddr", burst_addr_q[first + 1], base + 64);
        check_value("burst 0 awid", 32'(burst_id_q[first]), 32'h0);
        check_value("burst 1 awid", 32'(burst_id_q[first + 1]), 32'h0);
        verify_window(base, 8'h20, 0, 0, 32);
        write_reg(REG_CTRL, 32'h0);
    endtask

    task automatic capture_two_channels();
        int first;
        first = bursts_done;
        set_window(0, 32'h2000_0000, 32'h1000);
        set_window(1, 32'h2100_0000, 32'h1000);
        write_reg(REG_CTRL, 32'h3);
        pulse_vsync(2'b11);
        send_pixels(2'b11, 48, 8'h30);
        wait_bursts(first + 6);
        for (int k = first + 1; k < first + 6; k++) begin
            check_value("awid toggle", 32'(burst_id_q[k] != burst_id_q[k - 1]), 32'h1);
        end
        verify_window(32'h2000_0000, 8'h30, 0, 0, 48);
        verify_window(32'h2100_0000, 8'h30, 1, 0, 48);
        write_reg(REG_CTRL, 32'h0);
    endtask

    task automatic wrap_window();
        addr_t base;
        int    first;
        base  = 32'h3000_0000;
        first = bursts_done;
        set_window(0, base, 32'h80);
        write_reg(REG_CTRL, 32'h1);
        pulse_vsync(2'b01);
        send_pixels(2'b01, 64, 8'h40);
        wait_bursts(first + 4);
        for (int k = 0; k < 4; k++) begin
            check_value($sformatf("burst %0d awaddr", k), burst_addr_q[first + k],
                        base + addr_t'(64 * (k % 2)));
        end
        verify_window(base, 8'h40, 0, 32, 32);   // second pass overwrote the first.
        write_reg(REG_CTRL, 32'h0);
    endtask

    task automatic backpressure_and_overflow();
        word_t rd;
        int    first;
        rand_ready = 1'b1;
        first      = bursts_done;
        set_window(1, 32'h4100_0000, 32'h100);
        write_reg(REG_CTRL, 32'h2);
        pulse_vsync(2'b10);
        send_pixels(2'b10, 64, 8'h50);
        wait_bursts(first + 4);
        verify_window(32'h4100_0000, 8'h50, 1, 0, 64);
        rand_ready = 1'b0;
        write_reg(REG_CTRL, 32'h0);

        // stall W so the fifo fills and drops 16 pixels.
        hold_wready = 1'b1;
        first       = bursts_done;
        set_window(0, 32'h4000_0000, 32'h100);
        write_reg(REG_CTRL, 32'h1);
        pulse_vsync(2'b01);
        send_pixels(2'b01, 80, 8'h51);
        read_reg(REG_STATUS, rd);
        check_value("status overflow", rd, 32'h1);
        write_reg(REG_STATUS, 32'h1);
        read_reg(REG_STATUS, rd);
        check_value("status cleared", rd, 32'h0);
        hold_wready = 1'b0;
        wait_bursts(first + 4);
        verify_window(32'h4000_0000, 8'h51, 0, 0, 64);
        write_reg(REG_CTRL, 32'h0);
    endtask

    task automatic error_response();
        word_t rd;
        int    first;
        force_err = 1'b1;
        first     = bursts_done;
        set_window(0, 32'h5000_0000, 32'h40);
        write_reg(REG_CTRL, 32'h1);
        pulse_vsync(2'b01);
        send_pixels(2'b01, 16, 8'h60);
        wait_bursts(first + 1);
        force_err = 1'b0;
        read_reg(REG_STATUS, rd);
        check_value("status write error", rd, 32'h4);
        write_reg(REG_STATUS, 32'h4);
        read_reg(REG_STATUS, rd);
        check_value("status cleared", rd, 32'h0);
        write_reg(REG_CTRL, 32'h0);
    endtask

    // ------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        vsync       = '0;
        de          = '0;
        rand_ready  = 1'b0;
        hold_wready = 1'b0;
        force_err   = 1'b0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            rgb[ch] = '0;
        end
        @(negedge rst);
        @(posedge clk);
        #1;
        check_reset_and_regs();
        capture_single_channel();
        capture_two_channels();
        wrap_window();
        backpressure_and_overflow();
        error_response();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout: the tests did not complete in the allowed time");
    end

endmodule

// ==== stream_dma_top.f ====
stream_dma_pkg.sv
dma_capture_regs.sv
capture_channel.sv
axi_burst_writer.sv
stream_dma_top.sv
tb_clock_gen.sv
stream_dma_props.sv
stream_dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= stream_dma_tb
FILELIST  ?= stream_dma_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
